// File: Makefile
# Verilator build and run of the codec init testbench
SIM  := obj_dir/Vtb_codec_init
SRCS := $(shell grep -v '^+' files.f)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) files.f
	verilator --binary --timing --assert -f files.f --top-module tb_codec_init \
		-o Vtb_codec_init

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^TEST PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: codec_cfg_pkg.sv
package codec_cfg_pkg;

    // Bus opcodes issued by the control FSM
    typedef enum logic [1:0] {
        OP_START = 2'd0,
        OP_WRITE = 2'd1,
        OP_STOP  = 2'd2
    } i2c_op_e;

    // One bus command, data only matters for OP_WRITE
    typedef struct packed {
        i2c_op_e    op;
        logic [7:0] data;
    } i2c_cmd_t;

    // Result of one command
    typedef struct packed {
        logic nack;     // SDA left high in the ack slot
    } i2c_rsp_t;

    // One codec register word, as sent in bytes two and three
    typedef struct packed {
        logic [6:0] reg_addr;
        logic [8:0] reg_data;
    } codec_reg_t;

    // Codec slave address, goes out as 0x34 with the write bit
    localparam logic [6:0] CODEC_DEV_ADDR = 7'h1A;
    localparam logic       I2C_WR_BIT     = 1'b0;

    // Register table size and index width
    localparam int NUM_REGS = 10;
    localparam int IDX_W    = 4;
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(NUM_REGS - 1);

    // Quarter-bit tick divider, kept short for simulation
    localparam int TICK_DIV   = 4;
    localparam int TICK_CNT_W = $clog2(TICK_DIV);
    localparam logic [TICK_CNT_W-1:0] TICK_LAST = TICK_CNT_W'(TICK_DIV - 1);

    // Retries per register after the first attempt
    localparam int MAX_RETRY = 2;
    localparam int RETRY_W   = $clog2(MAX_RETRY + 1);
    localparam logic [RETRY_W-1:0] RETRY_LAST = RETRY_W'(MAX_RETRY);

endpackage

// File: codec_init_ctrl.sv
`timescale 1ns/1ps

module codec_init_ctrl (
    input  logic                              i_clk,
    input  logic                              i_rst_n,
    input  logic                              i_start,
    output logic                              o_busy,
    output logic                              o_done,
    output logic                              o_error,
    output logic [codec_cfg_pkg::IDX_W-1:0]   o_index,
    input  codec_cfg_pkg::codec_reg_t         i_word,
    output logic                              o_cmd_valid,
    output codec_cfg_pkg::i2c_cmd_t           o_cmd,
    input  logic                              i_cmd_ready,
    input  logic                              i_rsp_valid,
    input  codec_cfg_pkg::i2c_rsp_t           i_rsp
);

    // Each state names the command it issues
    typedef enum logic [2:0] {
        CT_IDLE,
        CT_START,
        CT_DEV,
        CT_REG,
        CT_DATA,
        CT_STOP
    } ctrl_state_e;

    ctrl_state_e                        state_q;
    logic                               issued_q;   // Command accepted, waiting for rsp
    logic                               nacked_q;   // Current attempt failed
    logic                               done_q;
    logic                               error_q;
    logic [codec_cfg_pkg::IDX_W-1:0]    idx_q;
    logic [codec_cfg_pkg::RETRY_W-1:0]  retry_q;

    // Command for the current state
    always_comb begin
        o_cmd.op   = codec_cfg_pkg::OP_WRITE;
        o_cmd.data = 8'h00;
        case (state_q)
            CT_START: o_cmd.op   = codec_cfg_pkg::OP_START;
            CT_DEV:   o_cmd.data = {codec_cfg_pkg::CODEC_DEV_ADDR, codec_cfg_pkg::I2C_WR_BIT};
            CT_REG:   o_cmd.data = {i_word.reg_addr, i_word.reg_data[8]};
            CT_DATA:  o_cmd.data = i_word.reg_data[7:0];
            CT_STOP:  o_cmd.op   = codec_cfg_pkg::OP_STOP;
            default:  o_cmd.data = 8'h00;
        endcase
    end

    assign o_cmd_valid = (state_q != CT_IDLE) && !issued_q;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q  <= CT_IDLE;
            issued_q <= 1'b0;
            nacked_q <= 1'b0;
            done_q   <= 1'b0;
            error_q  <= 1'b0;
            idx_q    <= '0;
            retry_q  <= '0;
        end else begin
            done_q <= 1'b0;
            if (i_rsp_valid) begin
                issued_q <= 1'b0;
            end else if (o_cmd_valid && i_cmd_ready) begin
                issued_q <= 1'b1;
            end
            case (state_q)
                CT_IDLE: begin
                    if (i_start) begin
                        state_q  <= CT_START;
                        idx_q    <= '0;
                        retry_q  <= '0;
                        nacked_q <= 1'b0;
                        error_q  <= 1'b0;   // Error is kept until the next start
                    end
                end
                CT_START: begin
                    if (i_rsp_valid) begin
                        state_q <= CT_DEV;
                    end
                end
                CT_DEV, CT_REG: begin
                    if (i_rsp_valid) begin
                        if (i_rsp.nack) begin
                            nacked_q <= 1'b1;   // Drop the rest of the transaction
                            state_q  <= CT_STOP;
                        end else begin
                            state_q <= (state_q == CT_DEV) ? CT_REG : CT_DATA;
                        end
                    end
                end
                CT_DATA: begin
                    if (i_rsp_valid) begin
                        nacked_q <= i_rsp.nack;
                        state_q  <= CT_STOP;
                    end
                end
                CT_STOP: begin
                    if (i_rsp_valid) begin
                        nacked_q <= 1'b0;
                        if (nacked_q) begin
                            if (retry_q == codec_cfg_pkg::RETRY_LAST) begin
                                error_q <= 1'b1;    // Retries used up
                                done_q  <= 1'b1;
                                state_q <= CT_IDLE;
                            end else begin
                                retry_q <= retry_q + 1'b1;
                                state_q <= CT_START;    // Same register again
                            end
                        end else if (idx_q == codec_cfg_pkg::LAST_IDX) begin
                            done_q  <= 1'b1;
                            state_q <= CT_IDLE;
                        end else begin
                            idx_q   <= idx_q + 1'b1;
                            retry_q <= '0;
                            state_q <= CT_START;
                        end
                    end
                end
                default: state_q <= CT_IDLE;
            endcase
        end
    end

    assign o_busy  = (state_q != CT_IDLE);
    assign o_done  = done_q;
    assign o_error = error_q;
    assign o_index = idx_q;

    // Command must wait unchanged for the engine
    property p_cmd_hold;
        @(posedge i_clk) disable iff (!i_rst_n)
            (o_cmd_valid && !i_cmd_ready) |=> (o_cmd_valid && $stable(o_cmd));
    endproperty
    a_cmd_hold: assert property (p_cmd_hold)
        else $error("codec_init_ctrl: command changed before the engine took it");

endmodule

// File: codec_init_top.sv
`timescale 1ns/1ps

module codec_init_top (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_start,
    output logic o_busy,
    output logic o_done,
    output logic o_error,
    output logic o_sclk,
    output logic o_sdat,
    output logic o_sdat_oen,
    input  logic i_sdat
);

    logic [codec_cfg_pkg::IDX_W-1:0] reg_index;
    codec_cfg_pkg::codec_reg_t       reg_word;
    logic                            cmd_valid;
    logic                            cmd_ready;
    codec_cfg_pkg::i2c_cmd_t         cmd;
    logic                            rsp_valid;
    codec_cfg_pkg::i2c_rsp_t         rsp;
    logic                            tick;
    logic                            run;

    codec_init_ctrl u_ctrl (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_start     (i_start),
        .o_busy      (o_busy),
        .o_done      (o_done),
        .o_error     (o_error),
        .o_index     (reg_index),
        .i_word      (reg_word),
        .o_cmd_valid (cmd_valid),
        .o_cmd       (cmd),
        .i_cmd_ready (cmd_ready),
        .i_rsp_valid (rsp_valid),
        .i_rsp       (rsp)
    );

    codec_reg_rom u_rom (
        .i_index (reg_index),
        .o_word  (reg_word)
    );

    i2c_tick_gen u_tick (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_run   (run),
        .o_tick  (tick)
    );

    i2c_bit_engine u_engine (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_cmd_valid (cmd_valid),
        .i_cmd       (cmd),
        .o_cmd_ready (cmd_ready),
        .o_rsp_valid (rsp_valid),
        .o_rsp       (rsp),
        .i_tick      (tick),
        .o_run       (run),
        .i_sdat      (i_sdat),
        .o_sclk      (o_sclk),
        .o_sdat      (o_sdat),
        .o_sdat_oen  (o_sdat_oen)
    );

endmodule

// File: codec_reg_rom.sv
`timescale 1ns/1ps

module codec_reg_rom (
    input  logic [codec_cfg_pkg::IDX_W-1:0] i_index,
    output codec_cfg_pkg::codec_reg_t       o_word
);

    always_comb begin
        o_word = '0;    // Out of range reads give zero
        case (i_index)
            4'd0: o_word = '{reg_addr: 7'h00, reg_data: 9'h097};  // Left line in, muted
            4'd1: o_word = '{reg_addr: 7'h01, reg_data: 9'h097};  // Right line in, muted
            4'd2: o_word = '{reg_addr: 7'h02, reg_data: 9'h079};  // Left headphone, 0 dB
            4'd3: o_word = '{reg_addr: 7'h03, reg_data: 9'h079};  // Right headphone, 0 dB
            4'd4: o_word = '{reg_addr: 7'h04, reg_data: 9'h015};  // Analog path, mic with boost
            4'd5: o_word = '{reg_addr: 7'h05, reg_data: 9'h000};  // Digital path, DAC unmuted
            4'd6: o_word = '{reg_addr: 7'h06, reg_data: 9'h000};  // Power down, all on
            4'd7: o_word = '{reg_addr: 7'h07, reg_data: 9'h042};  // Master, I2S, 16 bit
            4'd8: o_word = '{reg_addr: 7'h08, reg_data: 9'h019};  // USB mode, 32 kHz
            4'd9: o_word = '{reg_addr: 7'h09, reg_data: 9'h001};  // Activate interface
            default: o_word = '0;
        endcase
    end

    // Reads past the last table entry
    always_comb begin
        assert (i_index <= codec_cfg_pkg::LAST_IDX)
        else $error("codec_reg_rom: read of index %0d beyond the table", i_index);
    end

endmodule

// File: files.f
codec_cfg_pkg.sv
codec_reg_rom.sv
i2c_tick_gen.sv
i2c_bit_engine.sv
codec_init_ctrl.sv
codec_init_top.sv
tb_i2c_checker.sv
tb_codec_init.sv

// File: i2c_bit_engine.sv
`timescale 1ns/1ps

module i2c_bit_engine (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_cmd_valid,
    input  codec_cfg_pkg::i2c_cmd_t i_cmd,
    output logic                    o_cmd_ready,
    output logic                    o_rsp_valid,
    output codec_cfg_pkg::i2c_rsp_t o_rsp,
    input  logic                    i_tick,
    output logic                    o_run,
    input  logic                    i_sdat,
    output logic                    o_sclk,
    output logic                    o_sdat,
    output logic                    o_sdat_oen
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_START,
        ST_BITS,
        ST_ACK,
        ST_STOP
    } eng_state_e;

    eng_state_e state_q;
    logic [1:0] phase_q;        // Quarter of the current bit
    logic [2:0] bit_cnt_q;
    logic [7:0] shift_q;
    logic       sclk_q;
    logic       sdat_q;
    logic       oen_q;
    logic       rsp_valid_q;
    logic       nack_q;
    logic       accept;
    logic       bit_end;

    assign accept  = i_cmd_valid && (state_q == ST_IDLE);
    assign bit_end = (state_q == ST_BITS) && i_tick && (phase_q == 2'd3);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q     <= ST_IDLE;
            phase_q     <= 2'd0;
            bit_cnt_q   <= 3'd0;
            sclk_q      <= 1'b1;
            sdat_q      <= 1'b1;
            oen_q       <= 1'b0;
            rsp_valid_q <= 1'b0;
            nack_q      <= 1'b0;
        end else begin
            rsp_valid_q <= 1'b0;
            if (state_q != ST_IDLE && i_tick) begin
                phase_q <= phase_q + 2'd1;  // Wraps after four ticks
            end
            case (state_q)
                ST_IDLE: begin
                    if (accept) begin
                        phase_q   <= 2'd0;
                        bit_cnt_q <= 3'd0;
                        nack_q    <= 1'b0;
                        case (i_cmd.op)
                            codec_cfg_pkg::OP_START: state_q <= ST_START;
                            codec_cfg_pkg::OP_WRITE: state_q <= ST_BITS;
                            default:                 state_q <= ST_STOP;
                        endcase
                    end
                end
                ST_START: begin
                    if (i_tick) begin
                        case (phase_q)
                            2'd0: begin
                                oen_q  <= 1'b1;   // Take SDA, still high
                                sdat_q <= 1'b1;
                            end
                            2'd1: sdat_q <= 1'b0; // Start, SDA falls under high SCL
                            2'd3: begin
                                sclk_q      <= 1'b0;
                                state_q     <= ST_IDLE;
                                rsp_valid_q <= 1'b1;
                            end
                            default: sclk_q <= 1'b1;
                        endcase
                    end
                end
                ST_BITS: begin
                    if (i_tick) begin
                        case (phase_q)
                            2'd0: sclk_q <= 1'b0;
                            2'd1: begin
                                oen_q  <= 1'b1;
                                sdat_q <= shift_q[7];     // MSB first
                            end
                            2'd2: sclk_q <= 1'b1;
                            default: begin
                                bit_cnt_q <= bit_cnt_q + 3'd1;
                                if (bit_cnt_q == 3'd7) begin
                                    state_q <= ST_ACK;
                                end
                            end
                        endcase
                    end
                end
                ST_ACK: begin
                    if (i_tick) begin
                        case (phase_q)
                            2'd0: sclk_q <= 1'b0;
                            2'd1: oen_q  <= 1'b0; // Let the slave drive
                            2'd2: sclk_q <= 1'b1;
                            default: begin
                                nack_q      <= i_sdat;    // Sampled with SCL high
                                state_q     <= ST_IDLE;
                                rsp_valid_q <= 1'b1;
                            end
                        endcase
                    end
                end
                ST_STOP: begin
                    if (i_tick) begin
                        case (phase_q)
                            2'd0: sclk_q <= 1'b0;
                            2'd1: begin
                                oen_q  <= 1'b1;
                                sdat_q <= 1'b0;
                            end
                            2'd2: sclk_q <= 1'b1;
                            default: begin
                                sdat_q      <= 1'b1;      // Stop, SDA rises under high SCL
                                oen_q       <= 1'b0;
                                state_q     <= ST_IDLE;
                                rsp_valid_q <= 1'b1;
                            end
                        endcase
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Byte shifter
    always_ff @(posedge i_clk) begin
        if (accept) begin
            shift_q <= i_cmd.data;
        end else if (bit_end) begin
            shift_q <= {shift_q[6:0], 1'b0};
        end
    end

    assign o_cmd_ready = (state_q == ST_IDLE);
    assign o_run       = (state_q != ST_IDLE);
    assign o_rsp_valid = rsp_valid_q;
    assign o_rsp.nack  = nack_q;
    assign o_sclk      = sclk_q;
    assign o_sdat      = sdat_q;
    assign o_sdat_oen  = oen_q;

    // Outside start and stop, our SDA drive holds while SCL stays high
    property p_sda_stable_scl_high;
        @(posedge i_clk) disable iff (!i_rst_n)
            (o_sclk && $past(o_sclk) && !($past(state_q) inside {ST_START, ST_STOP}))
            |-> ($stable(o_sdat) && $stable(o_sdat_oen));
    endproperty
    a_sda_stable_scl_high: assert property (p_sda_stable_scl_high)
        else $error("i2c_bit_engine: SDA changed while SCL was high");

endmodule

// File: i2c_tick_gen.sv
`timescale 1ns/1ps

module i2c_tick_gen (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_run,
    output logic o_tick
);

    logic [codec_cfg_pkg::TICK_CNT_W-1:0] cnt_q;

    // Counter held at zero between commands
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cnt_q <= '0;
        end else if (!i_run) begin
            cnt_q <= '0;
        end else if (cnt_q == codec_cfg_pkg::TICK_LAST) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // First tick lands TICK_DIV cycles into a command
    assign o_tick = i_run && (cnt_q == codec_cfg_pkg::TICK_LAST);

endmodule

// File: tb_codec_init.sv
`timescale 1ns/1ps

module tb_codec_init;

    logic        clk      = 1'b0;
    logic        rst_n    = 1'b0;
    logic        start    = 1'b0;
    logic        slave_sda = 1'b1;  // Low means the slave pulls SDA down
    logic        busy;
    logic        done;
    logic        error;
    logic        sclk;
    logic        sdat;
    logic        sdat_oen;
    logic        sda_line;
    logic        ack_valid;
    logic        ack_nack;
    logic        scl_prev;
    logic        sda_prev;
    logic        in_ack;
    logic [3:0]  bit_cnt;
    int unsigned draw_idx;
    bit          nack_plan [1024];  // Pre-drawn ack decisions
    int          chk_errors;
    int          chk_seqs;
    int          chk_txns;
    int          chk_nacks;

    always #20 clk = ~clk;

    // Open-drain bus with pull-up
    assign sda_line = (sdat_oen ? sdat : 1'b1) & slave_sda;

    codec_init_top dut (
        .i_clk      (clk),
        .i_rst_n    (rst_n),
        .i_start    (start),
        .o_busy     (busy),
        .o_done     (done),
        .o_error    (error),
        .o_sclk     (sclk),
        .o_sdat     (sdat),
        .o_sdat_oen (sdat_oen),
        .i_sdat     (sda_line)
    );

    tb_i2c_checker u_checker (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_scl       (sclk),
        .i_sda       (sda_line),
        .i_sdat      (sdat),
        .i_sdat_oen  (sdat_oen),
        .i_busy      (busy),
        .i_done      (done),
        .i_error     (error),
        .i_ack_valid (ack_valid),
        .i_ack_nack  (ack_nack),
        .o_errors    (chk_errors),
        .o_seqs      (chk_seqs),
        .o_txns      (chk_txns),
        .o_nacks     (chk_nacks)
    );

    // Codec slave, acks after eight bits and sometimes leaves SDA high
    always @(negedge clk) begin
        if (!rst_n) begin
            slave_sda <= 1'b1;
            ack_valid <= 1'b0;
            ack_nack  <= 1'b0;
            scl_prev  <= 1'b1;
            sda_prev  <= 1'b1;
            in_ack    <= 1'b0;
            bit_cnt   <= 4'd0;
            draw_idx  <= 0;
        end else begin
            ack_valid <= 1'b0;
            scl_prev  <= sclk;
            sda_prev  <= sda_line;
            if (sclk && scl_prev && sda_prev && !sda_line) begin
                bit_cnt <= 4'd0;                    // Start
            end else if (sclk && !scl_prev) begin
                if (!in_ack && bit_cnt < 4'd8) begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else if (!sclk && scl_prev) begin
                if (in_ack) begin
                    slave_sda <= 1'b1;              // Release after the ack slot
                    in_ack    <= 1'b0;
                    bit_cnt   <= 4'd0;
                end else if (bit_cnt == 4'd8) begin
                    slave_sda <= nack_plan[draw_idx % 1024];
                    ack_nack  <= nack_plan[draw_idx % 1024];
                    ack_valid <= 1'b1;
                    in_ack    <= 1'b1;
                    draw_idx  <= draw_idx + 1;
                end
            end
        end
    end

    task automatic pulse_start();
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic wait_done(input int limit, output bit timed_out);
        int cycles;
        cycles    = 0;
        timed_out = 1'b0;
        while (!done && !timed_out) begin
            @(negedge clk);
            cycles++;
            if (cycles > limit) begin
                timed_out = 1'b1;
            end
        end
    endtask

    initial begin
        bit timed_out;
        int timeouts;
        timeouts  = 0;
        timed_out = 1'b0;
        void'($urandom(21749));
        for (int i = 0; i < 1024; i++) begin
            nack_plan[i] = ($urandom % 8) == 0;     // About one nack in eight
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (10) @(negedge clk);
        for (int s = 0; s < 4; s++) begin
            pulse_start();
            if (s == 2) begin
                repeat (100 + $urandom % 400) @(negedge clk);
                pulse_start();                      // Sequence still running
            end
            wait_done(40000, timed_out);
            if (timed_out) begin
                $display("error: o_done did not arrive in time in sequence %0d", s);
                timeouts++;
                break;
            end
            repeat (5 + $urandom % 50) @(negedge clk);
        end
        $display("errors=%0d timeouts=%0d sequences=%0d transactions=%0d nacks=%0d",
                 chk_errors, timeouts, chk_seqs, chk_txns, chk_nacks);
        if (chk_errors == 0 && timeouts == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: tb_i2c_checker.sv
`timescale 1ns/1ps

module tb_i2c_checker (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_scl,         // SCL from the DUT
    input  logic i_sda,         // Resolved SDA line
    input  logic i_sdat,
    input  logic i_sdat_oen,
    input  logic i_busy,
    input  logic i_done,
    input  logic i_error,
    input  logic i_ack_valid,   // Ack report from the slave model
    input  logic i_ack_nack,
    output int   o_errors,
    output int   o_seqs,
    output int   o_txns,
    output int   o_nacks
);

    logic       scl_q;
    logic       sda_q;
    logic       busy_q;
    logic       rst_checked;
    logic       in_txn;
    logic       nacked;         // Current transaction got a nack
    logic       nack_rep;
    logic       exp_end;
    logic       exp_error;
    logic [8:0] shreg;          // Eight data bits and the ack bit
    int         bits;
    int         nbytes;
    int         idx;
    int         fails;

    // Codec table as {reg_addr, reg_data}
    function automatic logic [15:0] table_word(input int i);
        case (i)
            0: return {7'h00, 9'h097};
            1: return {7'h01, 9'h097};
            2: return {7'h02, 9'h079};
            3: return {7'h03, 9'h079};
            4: return {7'h04, 9'h015};
            5: return {7'h05, 9'h000};
            6: return {7'h06, 9'h000};
            7: return {7'h07, 9'h042};
            8: return {7'h08, 9'h019};
            9: return {7'h09, 9'h001};
            default: return 16'h0000;
        endcase
    endfunction

    function automatic logic [7:0] expected_byte(input int i, input int k);
        logic [15:0] w;
        w = table_word(i);
        case (k)
            0: return 8'h34;            // Address 0x1A with write bit
            1: return w[15:8];          // Register address and data bit 8
            default: return w[7:0];
        endcase
    endfunction

    task automatic compare_value(input string name, input logic [7:0] exp,
                                 input logic [7:0] got);
        if (exp !== got) begin
            $display("mismatch %s: expected 0x%h, got 0x%h at %0t", name, exp, got, $time);
            o_errors++;
        end
    endtask

    task automatic report_problem(input string msg);
        $display("error: %s at %0t", msg, $time);
        o_errors++;
    endtask

    task automatic finish_byte();
        compare_value("sda ack bit", 8'(nack_rep), 8'(shreg[0]));
        if (nacked) begin
            report_problem("byte sent after a nack in the same transaction");
        end else if (nbytes > 2) begin
            report_problem("more than three bytes in one transaction");
        end else begin
            compare_value($sformatf("o_sdat byte %0d of register %0d", nbytes, idx),
                          expected_byte(idx, nbytes), shreg[8:1]);
        end
        if (shreg[0]) begin
            nacked = 1'b1;
            o_nacks++;
        end
        nbytes++;
    endtask

    task automatic finish_transaction();
        o_txns++;
        if (nacked) begin
            fails++;
            if (fails > codec_cfg_pkg::MAX_RETRY) begin
                exp_end   = 1'b1;       // Retries used up
                exp_error = 1'b1;
            end
        end else begin
            if (nbytes != 3) begin
                report_problem($sformatf("transaction ended after %0d bytes without a nack",
                                         nbytes));
            end
            idx++;
            fails = 0;
            if (idx == codec_cfg_pkg::NUM_REGS) begin
                exp_end   = 1'b1;
                exp_error = 1'b0;
            end
        end
    endtask

    always @(negedge i_clk) begin
        if (!i_rst_n) begin
            o_errors    = 0;
            o_seqs      = 0;
            o_txns      = 0;
            o_nacks     = 0;
            scl_q       = 1'b1;
            sda_q       = 1'b1;
            busy_q      = 1'b0;
            rst_checked = 1'b0;
            in_txn      = 1'b0;
            nacked      = 1'b0;
            nack_rep    = 1'b0;
            exp_end     = 1'b0;
            exp_error   = 1'b0;
            shreg       = '0;
            bits        = 0;
            nbytes      = 0;
            idx         = 0;
            fails       = 0;
        end else begin
            if (!rst_checked) begin
                rst_checked = 1'b1;     // Idle state right after reset
                compare_value("o_sclk", 8'h01, 8'(i_scl));
                compare_value("o_sdat", 8'h01, 8'(i_sdat));
                compare_value("o_sdat_oen", 8'h00, 8'(i_sdat_oen));
                compare_value("o_busy", 8'h00, 8'(i_busy));
                compare_value("o_done", 8'h00, 8'(i_done));
                compare_value("o_error", 8'h00, 8'(i_error));
            end
            if (i_busy && !busy_q) begin
                idx       = 0;          // New sequence from register 0
                fails     = 0;
                exp_end   = 1'b0;
                exp_error = 1'b0;
            end
            if (i_ack_valid) begin
                nack_rep = i_ack_nack;
            end
            if (i_scl && scl_q && sda_q && !i_sda) begin
                if (in_txn || exp_end || !i_busy) begin
                    report_problem("SDA fell while SCL was high outside an expected start");
                end
                in_txn = 1'b1;
                bits   = 0;
                nbytes = 0;
                nacked = 1'b0;
            end else if (i_scl && scl_q && !sda_q && i_sda) begin
                // The stop's own SCL pulse counts as one bit
                if (!in_txn || bits > 1) begin
                    report_problem("SDA rose while SCL was high inside a byte");
                end else begin
                    finish_transaction();
                end
                in_txn = 1'b0;
            end else if (in_txn && i_scl && !scl_q) begin
                shreg = {shreg[7:0], i_sda};
                bits++;
                if (bits == 9) begin
                    finish_byte();
                    bits = 0;
                end
            end
            if (i_done) begin
                o_seqs++;
                if (!exp_end) begin
                    report_problem("o_done came before the sequence was complete");
                end else begin
                    compare_value("o_error", 8'(exp_error), 8'(i_error));
                end
            end
            scl_q  = i_scl;
            sda_q  = i_sda;
            busy_q = i_busy;
        end
    end

endmodule
